// ==== test/backend_stimulus.txt ====
// Columns: instruction word, expected commit rd, expected commit value (hex)
// Each register is written before it is read, so the program repeats cleanly
00500093 01 00000005
ffd00113 02 fffffffd
002081b3 03 00000002
40208233 04 00000008
0f014293 05 ffffff0d
00409313 06 00000050
40115393 07 fffffffe
01c15413 08 0000000f
001124b3 09 00000001
00113533 0a 00000000
008365b3 0b 0000005f
0042f633 0c 00000008
00708013 00 00000000
001006b3 0d 00000005
00118713 0e 00000003
00170713 0e 00000004
00170713 0e 00000005
00e70733 0e 0000000a
001717b3 0f 00000140
4012d833 10 fffffff8
0012d8b3 11 07fffff8
0060b913 12 00000001
ffc12993 13 00000000
07f87a13 14 00000078

// ==== backend_top.f ====
+incdir+design
design/backend_pkg.sv
design/id_stage.sv
design/rat.sv
design/free_list.sv
design/rob.sv
design/int_rs.sv
design/prf.sv
design/backend_top.sv
test/backend_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f backend_top.f --top-module backend_top_tb -Mdir "$BUILD"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/Vbackend_top_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

// ==== test/backend_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module backend_top_tb;

    localparam int N_REC          = 24;            // Records in the stimulus file
    localparam int N_PASS         = 4;             // Enough writes to recycle physical registers
    localparam int N_TOTAL        = N_REC * N_PASS;
    localparam int ADDR_W         = $clog2(N_REC * 3);
    localparam int POP_TIMEOUT    = 200;
    localparam int COMMIT_TIMEOUT = 500;

    logic                 clk;
    logic                 rst_n_i;
    logic                 inst_valid_i;
    backend_pkg::xlen_t   inst_i;
    logic                 inst_pop_o;
    backend_pkg::commit_t commit_o;

    logic [31:0] stim_mem [N_REC * 3];             // {inst, rd, value} per record
    integer      seed;
    int          errors;
    int          faults;
    int          commit_cnt;

    backend_pkg::phys_reg_t map_model [32];        // Reference rename map
    backend_pkg::phys_reg_t free_model [$];

    backend_top dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_pop_o   (inst_pop_o),
        .commit_o     (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ########################################
    // Helpers

    function automatic logic [31:0] stim_word(input int rec, input int col);
        return stim_mem[ADDR_W'(rec * 3 + col)];
    endfunction

    // Free tags leave at dispatch and return at commit in the same order
    function automatic backend_pkg::phys_reg_t rename_old_tag(input logic [31:0] rd);
        backend_pkg::phys_reg_t old_tag;
        if (rd == 0) begin
            return '0;
        end
        old_tag = map_model[rd[4:0]];
        map_model[rd[4:0]] = free_model.pop_front();
        free_model.push_back(old_tag);
        return old_tag;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // One clock edge, with the commit port checked against the file order
    task automatic tick();
        int                     rec;
        backend_pkg::phys_reg_t old_tag;
        @(posedge clk);
        if (commit_o.valid) begin
            if (commit_cnt >= N_TOTAL) begin
                $display("Extra commit seen after all %0d instructions retired", N_TOTAL);
                faults++;
            end else begin
                rec = commit_cnt % N_REC;
                old_tag = rename_old_tag(stim_word(rec, 1));
                check_value("commit_o.rd_arch", 32'(commit_o.rd_arch), stim_word(rec, 1));
                check_value("commit_o.value", commit_o.value, stim_word(rec, 2));
                check_value("commit_o.old_phy", 32'(commit_o.old_phy), 32'(old_tag));
            end
            commit_cnt++;
        end
    endtask

    // Queue head stays put until the backend pops it
    task automatic present_inst(input int k);
        int   cycles;
        logic popped;
        popped = 1'b0;
        cycles = 0;
        while (!popped && cycles < POP_TIMEOUT) begin
            inst_i       <= stim_word(k % N_REC, 0);
            inst_valid_i <= (($random(seed) & 3) != 0);   // Drop valid about one cycle in four
            tick();
            popped = inst_valid_i && inst_pop_o;
            cycles++;
        end
        if (!popped) begin
            $display("Stall: instruction %0d was not taken within %0d cycles", k, POP_TIMEOUT);
            faults++;
        end
    endtask

    // ########################################
    // Main sequence

    initial begin
        int k;
        int cycles;
        seed         = 32'h0830cd2b;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        errors       = 0;
        faults       = 0;
        commit_cnt   = 0;
        $readmemh("test/backend_stimulus.txt", stim_mem);

        for (k = 0; k < 32; k++) begin
            map_model[k] = backend_pkg::phys_reg_t'(k);  // xi starts on pi
        end
        for (k = 32; k < 64; k++) begin
            free_model.push_back(backend_pkg::phys_reg_t'(k));
        end

        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;

        for (k = 0; k < 8; k++) begin                    // Empty queue, nothing moves
            tick();
            check_value("inst_pop_o", 32'(inst_pop_o), 32'h0);
            check_value("commit_o.valid", 32'(commit_o.valid), 32'h0);
        end

        for (k = 0; k < N_TOTAL && faults == 0; k++) begin
            present_inst(k);
        end
        inst_valid_i <= 1'b0;

        cycles = 0;
        while (commit_cnt < N_TOTAL && faults == 0 && cycles < COMMIT_TIMEOUT) begin
            tick();
            cycles++;
        end
        if (commit_cnt < N_TOTAL && faults == 0) begin
            $display("Stall: only %0d of %0d instructions committed", commit_cnt, N_TOTAL);
            faults++;
        end

        for (k = 0; k < 32; k++) begin                   // Catch late duplicates
            tick();
        end
        check_value("commit count", 32'(commit_cnt), 32'(N_TOTAL));

        $display("Value errors: %0d, other failures: %0d, commits: %0d of %0d",
                 errors, faults, commit_cnt, N_TOTAL);
        if (errors == 0 && faults == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/backend_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module backend_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 inst_valid_i,
    input  backend_pkg::xlen_t   inst_i,
    output logic                 inst_pop_o,
    output backend_pkg::commit_t commit_o
);

    // ######################################
    // Rename side

    backend_pkg::arch_reg_t  rs1_arch, rs2_arch, rd_arch;
    backend_pkg::phys_reg_t  rs1_phy, rs2_phy, old_phy;
    logic                    rs1_ready, rs2_ready;
    logic                    rat_we;
    logic                    fl_empty, fl_pop;
    backend_pkg::phys_reg_t  fl_tag;
    logic                    rob_full, rob_alloc_we;
    backend_pkg::rob_id_t    rob_id;
    backend_pkg::rob_alloc_t rob_alloc;
    logic                    rs_full, rs_we;
    backend_pkg::rs_entry_t  rs_entry;

    // ######################################
    // Execute side

    backend_pkg::phys_reg_t  prf_rs1_phy, prf_rs2_phy;
    backend_pkg::xlen_t      prf_rs1_val, prf_rs2_val;
    backend_pkg::cdb_t       cdb;                        // Single broadcast port

    id_stage id_stage_i (
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_pop_o     (inst_pop_o),
        .rs1_arch_o     (rs1_arch),
        .rs2_arch_o     (rs2_arch),
        .rd_arch_o      (rd_arch),
        .rs1_phy_i      (rs1_phy),
        .rs2_phy_i      (rs2_phy),
        .old_phy_i      (old_phy),
        .rs1_ready_i    (rs1_ready),
        .rs2_ready_i    (rs2_ready),
        .fl_empty_i     (fl_empty),
        .fl_tag_i       (fl_tag),
        .fl_pop_o       (fl_pop),
        .rob_full_i     (rob_full),
        .rob_id_i       (rob_id),
        .rob_alloc_o    (rob_alloc),
        .rob_alloc_we_o (rob_alloc_we),
        .rs_full_i      (rs_full),
        .rs_entry_o     (rs_entry),
        .rs_we_o        (rs_we),
        .rat_we_o       (rat_we)
    );

    rat rat_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rs1_arch_i     (rs1_arch),
        .rs2_arch_i     (rs2_arch),
        .rd_arch_i      (rd_arch),
        .rd_phy_i       (rob_alloc.rd_phy),
        .we_i           (rat_we),
        .cdb_i          (cdb),
        .rs1_phy_o      (rs1_phy),
        .rs2_phy_o      (rs2_phy),
        .old_phy_o      (old_phy),
        .rs1_ready_o    (rs1_ready),
        .rs2_ready_o    (rs2_ready)
    );

    free_list free_list_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pop_i          (fl_pop),
        .tag_o          (fl_tag),
        .empty_o        (fl_empty),
        .commit_i       (commit_o)
    );

    rob rob_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .alloc_i        (rob_alloc),
        .alloc_we_i     (rob_alloc_we),
        .alloc_id_o     (rob_id),
        .full_o         (rob_full),
        .cdb_i          (cdb),
        .commit_o       (commit_o)
    );

    int_rs int_rs_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .entry_i        (rs_entry),
        .we_i           (rs_we),
        .full_o         (rs_full),
        .cdb_i          (cdb),
        .rs1_phy_o      (prf_rs1_phy),
        .rs2_phy_o      (prf_rs2_phy),
        .rs1_val_i      (prf_rs1_val),
        .rs2_val_i      (prf_rs2_val),
        .cdb_o          (cdb)
    );

    prf prf_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .rs1_phy_i      (prf_rs1_phy),
        .rs2_phy_i      (prf_rs2_phy),
        .rs1_val_o      (prf_rs1_val),
        .rs2_val_o      (prf_rs2_val),
        .cdb_i          (cdb)
    );

endmodule

`default_nettype wire

// ==== design/prf.sv ====
`timescale 1ns/100ps
`include "backend_defines.svh"
`default_nettype none

module prf (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  backend_pkg::phys_reg_t rs1_phy_i,
    input  backend_pkg::phys_reg_t rs2_phy_i,
    output backend_pkg::xlen_t     rs1_val_o,
    output backend_pkg::xlen_t     rs2_val_o,
    input  backend_pkg::cdb_t      cdb_i
);

    backend_pkg::xlen_t regs_q [`BE_PHYS_REGS];

    // Architectural state starts at zero
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BE_PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (cdb_i.valid && (cdb_i.rd_phy != '0)) begin
            regs_q[cdb_i.rd_phy] <= cdb_i.value;
        end
    end

    assign rs1_val_o = (rs1_phy_i == '0) ? '0 :
                       (cdb_i.valid && (cdb_i.rd_phy == rs1_phy_i)) ? cdb_i.value :
                       regs_q[rs1_phy_i];
    assign rs2_val_o = (rs2_phy_i == '0) ? '0 :
                       (cdb_i.valid && (cdb_i.rd_phy == rs2_phy_i)) ? cdb_i.value :
                       regs_q[rs2_phy_i];

endmodule

`default_nettype wire

// ==== design/int_rs.sv ====
`timescale 1ns/100ps
`include "backend_defines.svh"
`default_nettype none

module int_rs (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  backend_pkg::rs_entry_t entry_i,
    input  logic                   we_i,
    output logic                   full_o,
    input  backend_pkg::cdb_t      cdb_i,
    output backend_pkg::phys_reg_t rs1_phy_o,
    output backend_pkg::phys_reg_t rs2_phy_o,
    input  backend_pkg::xlen_t     rs1_val_i,
    input  backend_pkg::xlen_t     rs2_val_i,
    output backend_pkg::cdb_t      cdb_o
);

    localparam int IW = $clog2(`BE_RS_DEPTH);
    localparam int CW = IW + 1;

    backend_pkg::rs_entry_t  ent_q   [`BE_RS_DEPTH];   // Index 0 is oldest
    backend_pkg::rs_entry_t  ent_nxt [`BE_RS_DEPTH];
    logic [CW-1:0]           count_q;
    logic [`BE_RS_DEPTH-1:0] vld;
    logic                    issue;
    logic [IW-1:0]           sel;
    logic [IW-1:0]           wr_idx;
    backend_pkg::rs_entry_t  iss;
    backend_pkg::xlen_t      opb;
    backend_pkg::xlen_t      alu_res;

    function automatic backend_pkg::rs_entry_t wake(backend_pkg::rs_entry_t e,
                                                    backend_pkg::cdb_t c);
        backend_pkg::rs_entry_t w;
        w = e;
        if (c.valid && (c.rd_phy == e.rs1_phy)) w.rs1_ready = 1'b1;
        if (c.valid && (c.rd_phy == e.rs2_phy)) w.rs2_ready = 1'b1;
        return w;
    endfunction

    // ######################################
    // Select and compaction

    always_comb begin
        issue = 1'b0;
        sel   = '0;
        for (int i = `BE_RS_DEPTH - 1; i >= 0; i--) begin
            vld[i] = (CW'(i) < count_q);
            if (vld[i] && ent_q[i].rs1_ready && ent_q[i].rs2_ready) begin
                issue = 1'b1;
                sel   = IW'(i);
            end
        end
    end

    assign wr_idx = IW'(count_q - CW'(issue));
    assign full_o = (count_q == CW'(`BE_RS_DEPTH));

    always_comb begin
        int j;
        for (int i = 0; i < `BE_RS_DEPTH; i++) begin
            j = (issue && (IW'(i) >= sel) && (i < `BE_RS_DEPTH - 1)) ? i + 1 : i;
            ent_nxt[i] = wake(ent_q[j], cdb_i);
        end
        if (we_i) begin
            ent_nxt[wr_idx] = wake(entry_i, cdb_i);    // Bypass on write
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `BE_RS_DEPTH; i++) begin
            ent_q[i] <= ent_nxt[i];
        end
    end

    // ######################################
    // Operand read and ALU

    assign iss       = ent_q[sel];
    assign rs1_phy_o = iss.rs1_phy;
    assign rs2_phy_o = iss.rs2_phy;
    assign opb       = iss.use_imm ? iss.imm : rs2_val_i;

    always_comb begin
        case (iss.op)
            4'b0000: alu_res = rs1_val_i + opb;
            4'b1000: alu_res = rs1_val_i - opb;
            4'b0001: alu_res = rs1_val_i << opb[4:0];
            4'b0010: alu_res = {31'b0, $signed(rs1_val_i) < $signed(opb)};
            4'b0011: alu_res = {31'b0, rs1_val_i < opb};
            4'b0100: alu_res = rs1_val_i ^ opb;
            4'b0101: alu_res = rs1_val_i >> opb[4:0];
            4'b1101: alu_res = $unsigned($signed(rs1_val_i) >>> opb[4:0]);
            4'b0110: alu_res = rs1_val_i | opb;
            4'b0111: alu_res = rs1_val_i & opb;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            cdb_o   <= '0;
        end else begin
            count_q      <= count_q + CW'(we_i) - CW'(issue);
            cdb_o.valid  <= issue;
            cdb_o.rob_id <= iss.rob_id;
            cdb_o.rd_phy <= iss.rd_phy;
            cdb_o.value  <= (iss.rd_phy == '0) ? '0 : alu_res;    // x0 result
        end
    end

endmodule

`default_nettype wire

// ==== design/rob.sv ====
`timescale 1ns/100ps
`include "backend_defines.svh"
`default_nettype none

module rob (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  backend_pkg::rob_alloc_t alloc_i,
    input  logic                    alloc_we_i,
    output backend_pkg::rob_id_t    alloc_id_o,
    output logic                    full_o,
    input  backend_pkg::cdb_t       cdb_i,
    output backend_pkg::commit_t    commit_o
);

    localparam int CW = $clog2(`BE_ROB_DEPTH) + 1;

    backend_pkg::rob_alloc_t  alloc_q [`BE_ROB_DEPTH];
    backend_pkg::xlen_t       value_q [`BE_ROB_DEPTH];
    logic [`BE_ROB_DEPTH-1:0] valid_q;
    logic [`BE_ROB_DEPTH-1:0] done_q;
    backend_pkg::rob_id_t     head_q;
    backend_pkg::rob_id_t     tail_q;
    logic [CW-1:0]            count_q;
    logic                     retire;

    assign alloc_id_o = tail_q;
    assign full_o     = (count_q == CW'(`BE_ROB_DEPTH));
    assign retire     = valid_q[head_q] & done_q[head_q];

    always_ff @(posedge clk) begin
        if (alloc_we_i) begin
            alloc_q[tail_q] <= alloc_i;
        end
        if (cdb_i.valid) begin
            value_q[cdb_i.rob_id] <= cdb_i.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= '0;
            done_q   <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            commit_o <= '0;
        end else begin
            commit_o.valid   <= retire;
            commit_o.rd_arch <= alloc_q[head_q].rd_arch;
            commit_o.old_phy <= alloc_q[head_q].old_phy;
            commit_o.value   <= value_q[head_q];
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            if (alloc_we_i) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.rob_id] <= 1'b1;
            end
            count_q <= count_q + CW'(alloc_we_i) - CW'(retire);
        end
    end

    a_cdb_hits_live: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb_i.valid |-> valid_q[cdb_i.rob_id]);

endmodule

`default_nettype wire

// ==== design/free_list.sv ====
`timescale 1ns/100ps
`include "backend_defines.svh"
`default_nettype none

module free_list (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   pop_i,
    output backend_pkg::phys_reg_t tag_o,
    output logic                   empty_o,
    input  backend_pkg::commit_t   commit_i
);

    localparam int PW = $clog2(`BE_PHYS_REGS);

    backend_pkg::phys_reg_t fifo_q [`BE_PHYS_REGS];
    logic [PW-1:0]          head_q;
    logic [PW-1:0]          tail_q;
    logic [PW:0]            count_q;
    logic                   push;

    assign push    = commit_i.valid && (commit_i.old_phy != '0);   // p0 is never recycled
    assign tag_o   = fifo_q[head_q];
    assign empty_o = (count_q == '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BE_PHYS_REGS; i++) begin
                fifo_q[i] <= backend_pkg::phys_reg_t'(i + `BE_ARCH_REGS);
            end
            head_q  <= '0;
            tail_q  <= PW'(`BE_PHYS_REGS - `BE_ARCH_REGS);
            count_q <= (PW+1)'(`BE_PHYS_REGS - `BE_ARCH_REGS);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push) begin
                fifo_q[tail_q] <= commit_i.old_phy;
                tail_q         <= tail_q + 1'b1;
            end
            count_q <= count_q + (PW+1)'(push) - (PW+1)'(pop_i);
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i) pop_i |-> !empty_o);
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        (push && !pop_i) |-> (count_q < (PW+1)'(`BE_PHYS_REGS)));

endmodule

`default_nettype wire

// ==== design/rat.sv ====
`timescale 1ns/100ps
`include "backend_defines.svh"
`default_nettype none

module rat (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  backend_pkg::arch_reg_t rs1_arch_i,
    input  backend_pkg::arch_reg_t rs2_arch_i,
    input  backend_pkg::arch_reg_t rd_arch_i,
    input  backend_pkg::phys_reg_t rd_phy_i,
    input  logic                   we_i,
    input  backend_pkg::cdb_t      cdb_i,
    output backend_pkg::phys_reg_t rs1_phy_o,
    output backend_pkg::phys_reg_t rs2_phy_o,
    output backend_pkg::phys_reg_t old_phy_o,
    output logic                   rs1_ready_o,
    output logic                   rs2_ready_o
);

    backend_pkg::phys_reg_t    map_q [`BE_ARCH_REGS];
    logic [`BE_ARCH_REGS-1:0]  ready_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BE_ARCH_REGS; i++) begin
                map_q[i] <= backend_pkg::phys_reg_t'(i);    // xi on pi
            end
            ready_q <= '1;
        end else begin
            for (int i = 0; i < `BE_ARCH_REGS; i++) begin
                if (cdb_i.valid && (map_q[i] == cdb_i.rd_phy)) begin
                    ready_q[i] <= 1'b1;
                end
            end
            if (we_i && (rd_arch_i != '0)) begin    // New producer wins over wakeup
                map_q[rd_arch_i]   <= rd_phy_i;
                ready_q[rd_arch_i] <= 1'b0;
            end
        end
    end

    assign rs1_phy_o = map_q[rs1_arch_i];
    assign rs2_phy_o = map_q[rs2_arch_i];
    assign old_phy_o = map_q[rd_arch_i];

    // Same-cycle CDB bypass
    assign rs1_ready_o = ready_q[rs1_arch_i] | (cdb_i.valid && (cdb_i.rd_phy == rs1_phy_o));
    assign rs2_ready_o = ready_q[rs2_arch_i] | (cdb_i.valid && (cdb_i.rd_phy == rs2_phy_o));

    // p0 belongs to x0 alone
    a_p0_only_x0: assert property (@(posedge clk) disable iff (!rst_n_i)
        (we_i && (rd_arch_i != '0)) |-> (rd_phy_i != '0));

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage (
    input  logic                    inst_valid_i,
    input  backend_pkg::xlen_t      inst_i,
    output logic                    inst_pop_o,
    output backend_pkg::arch_reg_t  rs1_arch_o,
    output backend_pkg::arch_reg_t  rs2_arch_o,
    output backend_pkg::arch_reg_t  rd_arch_o,
    input  backend_pkg::phys_reg_t  rs1_phy_i,
    input  backend_pkg::phys_reg_t  rs2_phy_i,
    input  backend_pkg::phys_reg_t  old_phy_i,
    input  logic                    rs1_ready_i,
    input  logic                    rs2_ready_i,
    input  logic                    fl_empty_i,
    input  backend_pkg::phys_reg_t  fl_tag_i,
    output logic                    fl_pop_o,
    input  logic                    rob_full_i,
    input  backend_pkg::rob_id_t    rob_id_i,
    output backend_pkg::rob_alloc_t rob_alloc_o,
    output logic                    rob_alloc_we_o,
    input  logic                    rs_full_i,
    output backend_pkg::rs_entry_t  rs_entry_o,
    output logic                    rs_we_o,
    output logic                    rat_we_o
);

    logic                   is_imm;
    logic [2:0]             funct3;
    logic                   rd_zero;
    logic                   dispatch;
    backend_pkg::phys_reg_t new_phy;

    assign is_imm     = ~inst_i[5];                 // OP-IMM has opcode bit 5 clear
    assign funct3     = inst_i[14:12];
    assign rs1_arch_o = inst_i[19:15];
    assign rs2_arch_o = is_imm ? '0 : inst_i[24:20];
    assign rd_arch_o  = inst_i[11:7];
    assign rd_zero    = (rd_arch_o == '0);
    assign new_phy    = rd_zero ? '0 : fl_tag_i;    // x0 stays on p0

    // One decision, fanned out to every consumer
    assign dispatch = inst_valid_i & ~rob_full_i & ~rs_full_i & (~fl_empty_i | rd_zero);

    assign inst_pop_o     = dispatch;
    assign rob_alloc_we_o = dispatch;
    assign rs_we_o        = dispatch;
    assign rat_we_o       = dispatch;
    assign fl_pop_o       = dispatch & ~rd_zero;

    assign rob_alloc_o.rd_arch = rd_arch_o;
    assign rob_alloc_o.rd_phy  = new_phy;
    assign rob_alloc_o.old_phy = old_phy_i;

    // funct7[5] only matters for OP and the immediate right shifts
    assign rs_entry_o.op        = {inst_i[30] & (~is_imm | (funct3 == 3'b101)), funct3};
    assign rs_entry_o.imm       = {{20{inst_i[31]}}, inst_i[31:20]};
    assign rs_entry_o.use_imm   = is_imm;
    assign rs_entry_o.rs1_phy   = rs1_phy_i;
    assign rs_entry_o.rs1_ready = rs1_ready_i;
    assign rs_entry_o.rs2_phy   = rs2_phy_i;
    assign rs_entry_o.rs2_ready = rs2_ready_i | is_imm;
    assign rs_entry_o.rd_phy    = new_phy;
    assign rs_entry_o.rob_id    = rob_id_i;

endmodule

`default_nettype wire

// ==== design/backend_pkg.sv ====
`include "backend_defines.svh"
`default_nettype none

package backend_pkg;

    typedef logic [`BE_XLEN-1:0]               xlen_t;
    typedef logic [$clog2(`BE_ARCH_REGS)-1:0]  arch_reg_t;
    typedef logic [$clog2(`BE_PHYS_REGS)-1:0]  phys_reg_t;
    typedef logic [$clog2(`BE_ROB_DEPTH)-1:0]  rob_id_t;
    typedef logic [3:0]                        alu_op_t;   // {funct7[5], funct3}

    typedef struct packed {
        alu_op_t   op;
        xlen_t     imm;
        logic      use_imm;
        phys_reg_t rs1_phy;
        logic      rs1_ready;
        phys_reg_t rs2_phy;
        logic      rs2_ready;
        phys_reg_t rd_phy;
        rob_id_t   rob_id;
    } rs_entry_t;

    typedef struct packed {
        arch_reg_t rd_arch;
        phys_reg_t rd_phy;
        phys_reg_t old_phy;     // Freed at commit
    } rob_alloc_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        phys_reg_t rd_phy;
        xlen_t     value;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd_arch;
        phys_reg_t old_phy;
        xlen_t     value;
    } commit_t;

endpackage

`default_nettype wire

// ==== design/backend_defines.svh ====
`default_nettype none

`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Datapath
`define BE_XLEN       32

// Register files
`define BE_ARCH_REGS  32
`define BE_PHYS_REGS  64

// Queues
`define BE_ROB_DEPTH  16
`define BE_RS_DEPTH   8

`endif

`default_nettype wire
